// File: src/kbd_pkg.sv
package kbd_pkg;

    // One byte as it comes off the PS/2 data line
    typedef logic [7:0] scan_code_t;

    // Bit 8 is the released flag, bits 7:0 the scan code
    typedef logic [8:0] key_event_t;

    // CPU bus side
    typedef logic [63:0] bus_addr_t;
    typedef logic [63:0] bus_data_t;
    typedef logic [3:0]  irq_vec_t;

    // Receiver FSM states
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

    // Prefix sent by the keyboard ahead of a release code
    localparam scan_code_t BREAK_PREFIX = 8'hF0;

    // Read value for addresses nobody decodes
    localparam bus_data_t UNMAPPED_DATA = 64'hDEAD_BEEF_DEAD_BEEF;

    // Vector raised for a keyboard event
    localparam irq_vec_t KEY_IRQ = 4'd1;

endpackage

// File: src/ps2_receiver.sv
`timescale 1ns/100ps

module ps2_receiver #(
    parameter int FRAME_TIMEOUT = 2000
) (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                ps2_clk,
    input  logic                ps2_dat,
    output logic                event_valid,
    output kbd_pkg::key_event_t event_data,
    output logic                frame_error,
    output kbd_pkg::scan_code_t last_code
);
    import kbd_pkg::*;

    localparam int TIMER_W = $clog2(FRAME_TIMEOUT + 1);

    logic [1:0]         clk_sync;
    logic [1:0]         dat_sync;
    logic               clk_prev;
    logic               ps2_fall;
    logic               ps2_dat_s;
    rx_state_t          state;
    logic [2:0]         bit_count;
    logic [TIMER_W-1:0] idle_timer;
    logic               release_armed;
    scan_code_t         shift_reg;
    logic               parity_bit;
    logic               frame_ok;

    // Both lines idle high, so the synchronisers come out of reset at one
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign ps2_fall  = clk_prev & ~clk_sync[1];
    assign ps2_dat_s = dat_sync[1];

    // Odd parity over data and parity bit, stop bit must be high
    assign frame_ok = (^{shift_reg, parity_bit}) & ps2_dat_s;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= RX_IDLE;
            bit_count     <= '0;
            idle_timer    <= '0;
            release_armed <= 1'b0;
            event_valid   <= 1'b0;
            frame_error   <= 1'b0;
            last_code     <= '0;
        end else begin
            event_valid <= 1'b0;
            frame_error <= 1'b0;

            if (state == RX_IDLE || ps2_fall) begin
                idle_timer <= '0;
            end else if (idle_timer == TIMER_W'(FRAME_TIMEOUT - 1)) begin
                // Stalled frame, drop it without a report
                idle_timer <= '0;
                state      <= RX_IDLE;
            end else begin
                idle_timer <= idle_timer + 1'b1;
            end

            if (ps2_fall) begin
                case (state)
                    RX_IDLE: begin
                        // Start bit is a low data line
                        if (!ps2_dat_s) begin
                            bit_count <= '0;
                            state     <= RX_DATA;
                        end
                    end
                    RX_DATA: begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: state <= RX_STOP;
                    RX_STOP: begin
                        state <= RX_IDLE;
                        if (!frame_ok) begin
                            frame_error   <= 1'b1;
                            release_armed <= 1'b0;
                        end else if (shift_reg == BREAK_PREFIX) begin
                            release_armed <= 1'b1;
                        end else begin
                            event_valid   <= 1'b1;
                            last_code     <= shift_reg;
                            release_armed <= 1'b0;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clock) begin
        if (ps2_fall) begin
            if (state == RX_DATA) begin
                shift_reg <= {ps2_dat_s, shift_reg[7:1]};
            end
            if (state == RX_PARITY) begin
                parity_bit <= ps2_dat_s;
            end
            if (state == RX_STOP) begin
                event_data <= {release_armed, shift_reg};
            end
        end
    end

    a_one_outcome: assert property (@(posedge clock) disable iff (!reset_n)
        !(event_valid && frame_error));

    a_single_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        event_valid |=> !event_valid);

endmodule

// File: src/key_fifo.sv
`timescale 1ns/100ps

module key_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                clock,
    input  logic                reset_n,
    input  logic                write,
    input  kbd_pkg::key_event_t write_data,
    input  logic                pop,
    input  logic                clear_overflow,
    output kbd_pkg::key_event_t head_data,
    output logic                not_empty,
    output logic                overflow
);
    import kbd_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    key_event_t     mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_write;

    assign full      = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign not_empty = (count != '0);
    assign do_write  = write & ~full;
    assign head_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= write_data;
        end
    end

    // Pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !do_write) begin
                count <= count - 1'b1;
            end

            // A fresh drop outranks a clear in the same cycle
            if (write && full) begin
                overflow <= 1'b1;
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

    a_pop_not_empty: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> not_empty);

endmodule

// File: src/kbd_bus_port.sv
`timescale 1ns/100ps

module kbd_bus_port #(
    parameter kbd_pkg::bus_addr_t KEY_BASE = 64'h0000_0000_8000_0010
) (
    input  logic                clock,
    input  logic                reset_n,
    input  kbd_pkg::bus_addr_t  bus_address,
    input  logic                bus_read_enable,
    input  kbd_pkg::key_event_t head_data,
    input  logic                not_empty,
    input  logic                overflow,
    input  logic                event_valid,
    input  logic                frame_error,
    input  logic                interrupt_done,
    output kbd_pkg::bus_data_t  bus_read_data,
    output logic                pop,
    output logic                clear_overflow,
    output kbd_pkg::irq_vec_t   interrupt_vector
);
    import kbd_pkg::*;

    localparam bus_addr_t STATUS_ADDR = KEY_BASE + 64'd4;

    logic      data_sel;
    logic      status_sel;
    logic      data_read;
    logic      status_read;
    logic      frame_error_flag;
    bus_data_t status_word;

    assign data_sel    = (bus_address == KEY_BASE);
    assign status_sel  = (bus_address == STATUS_ADDR);
    assign data_read   = bus_read_enable & data_sel;
    assign status_read = bus_read_enable & status_sel;

    // One event leaves the queue per cycle of data read
    assign pop            = data_read & not_empty;
    assign clear_overflow = status_read;

    assign status_word = bus_data_t'({frame_error_flag, overflow, not_empty});

    always_comb begin
        if (!bus_read_enable) begin
            bus_read_data = '0;
        end else if (data_sel) begin
            // Head is zero-extended, empty queue reads as zero
            bus_read_data = not_empty ? bus_data_t'(head_data) : '0;
        end else if (status_sel) begin
            bus_read_data = status_word;
        end else begin
            bus_read_data = UNMAPPED_DATA;
        end
    end

    // Sticky until the status word has been read
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            frame_error_flag <= 1'b0;
        end else if (frame_error) begin
            frame_error_flag <= 1'b1;
        end else if (status_read) begin
            frame_error_flag <= 1'b0;
        end
    end

    // Done takes priority over an event arriving in the same cycle
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            interrupt_vector <= '0;
        end else if (interrupt_done) begin
            interrupt_vector <= '0;
        end else if (event_valid) begin
            interrupt_vector <= KEY_IRQ;
        end
    end

    a_vector_legal: assert property (@(posedge clock) disable iff (!reset_n)
        interrupt_vector == '0 || interrupt_vector == KEY_IRQ);

endmodule

// File: src/kbd_top.sv
`timescale 1ns/100ps

module kbd_top #(
    parameter int                 FIFO_DEPTH    = 8,
    parameter int                 FRAME_TIMEOUT = 2000,
    parameter kbd_pkg::bus_addr_t KEY_BASE      = 64'h0000_0000_8000_0010
) (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               PS2_CLK,
    input  logic               PS2_DAT,
    input  kbd_pkg::bus_addr_t bus_address,
    input  logic               bus_read_enable,
    input  logic               interrupt_done,
    output kbd_pkg::bus_data_t bus_read_data,
    output kbd_pkg::irq_vec_t  interrupt_vector,
    output kbd_pkg::scan_code_t LEDG
);
    import kbd_pkg::*;

    logic       event_valid;
    key_event_t event_data;
    logic       frame_error;
    key_event_t head_data;
    logic       not_empty;
    logic       overflow;
    logic       pop;
    logic       clear_overflow;

    ps2_receiver #(
        .FRAME_TIMEOUT (FRAME_TIMEOUT)
    ) ps2_receiver_inst (
        .clock       (CLOCK_50),
        .reset_n     (KEY0),
        .ps2_clk     (PS2_CLK),
        .ps2_dat     (PS2_DAT),
        .event_valid (event_valid),
        .event_data  (event_data),
        .frame_error (frame_error),
        .last_code   (LEDG)
    );

    key_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) key_fifo_inst (
        .clock          (CLOCK_50),
        .reset_n        (KEY0),
        .write          (event_valid),
        .write_data     (event_data),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .head_data      (head_data),
        .not_empty      (not_empty),
        .overflow       (overflow)
    );

    kbd_bus_port #(
        .KEY_BASE (KEY_BASE)
    ) kbd_bus_port_inst (
        .clock            (CLOCK_50),
        .reset_n          (KEY0),
        .bus_address      (bus_address),
        .bus_read_enable  (bus_read_enable),
        .head_data        (head_data),
        .not_empty        (not_empty),
        .overflow         (overflow),
        .event_valid      (event_valid),
        .frame_error      (frame_error),
        .interrupt_done   (interrupt_done),
        .bus_read_data    (bus_read_data),
        .pop              (pop),
        .clear_overflow   (clear_overflow),
        .interrupt_vector (interrupt_vector)
    );

endmodule

// File: verification/kbd_tb.sv
`timescale 1ns/100ps

module kbd_tb;
    import kbd_pkg::*;

    localparam int        FIFO_DEPTH  = 8;
    localparam bus_addr_t KEY_BASE    = 64'h0000_0000_8000_0010;
    localparam bus_addr_t STATUS_ADDR = KEY_BASE + 64'd4;

    logic       CLOCK_50;
    logic       KEY0;
    logic       PS2_CLK;
    logic       PS2_DAT;
    bus_addr_t  bus_address;
    logic       bus_read_enable;
    logic       interrupt_done;
    bus_data_t  bus_read_data;
    irq_vec_t   interrupt_vector;
    scan_code_t LEDG;

    // Reference model of the event queue and the sticky status bits
    key_event_t model_q[$];
    logic       model_armed;
    logic       model_overflow;
    logic       model_frame_err;

    // Sampled reads waiting for the compare process
    string      name_q[$];
    bus_data_t  exp_q[$];
    bus_data_t  act_q[$];
    scan_code_t code;

    kbd_top #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .FRAME_TIMEOUT (300),
        .KEY_BASE      (KEY_BASE)
    ) kbd_top_inst (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .PS2_CLK          (PS2_CLK),
        .PS2_DAT          (PS2_DAT),
        .bus_address      (bus_address),
        .bus_read_enable  (bus_read_enable),
        .interrupt_done   (interrupt_done),
        .bus_read_data    (bus_read_data),
        .interrupt_vector (interrupt_vector),
        .LEDG             (LEDG)
    );

    always #50 CLOCK_50 = ~CLOCK_50;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            fail_run($sformatf("FAIL %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Good frames go into the model, breaks arm the released flag
    function automatic void model_frame(input scan_code_t frame_code, input bit good);
        if (!good) begin
            model_frame_err = 1'b1;
            model_armed     = 1'b0;
        end else if (frame_code == 8'hF0) begin
            model_armed = 1'b1;
        end else begin
            if (model_q.size() < FIFO_DEPTH) begin
                model_q.push_back({model_armed, frame_code});
            end else begin
                model_overflow = 1'b1;
            end
            model_armed = 1'b0;
        end
    endfunction

    // Expected read value, with the pop or sticky clear the read causes
    function automatic bus_data_t model_read(input bus_addr_t addr, input bit enable);
        bus_data_t result;
        logic      has_data;
        has_data = (model_q.size() > 0);
        if (!enable) begin
            result = '0;
        end else if (addr == KEY_BASE) begin
            result = has_data ? bus_data_t'(model_q.pop_front()) : '0;
        end else if (addr == STATUS_ADDR) begin
            result          = bus_data_t'({model_frame_err, model_overflow, has_data});
            model_frame_err = 1'b0;
            model_overflow  = 1'b0;
        end else begin
            result = 64'hDEAD_BEEF_DEAD_BEEF;
        end
        return result;
    endfunction

    // 40 clocks per bit, data changes mid high phase
    task automatic send_frame(input scan_code_t frame_code, input bit bad_parity,
                              input int bit_limit);
        logic [10:0] frame;
        logic        parity;
        parity = ~(^frame_code) ^ bad_parity;
        frame  = {1'b1, parity, frame_code, 1'b0};
        for (int i = 0; i < bit_limit; i++) begin
            repeat (10) @(posedge CLOCK_50);
            PS2_DAT <= frame[i];
            repeat (10) @(posedge CLOCK_50);
            PS2_CLK <= 1'b0;
            repeat (20) @(posedge CLOCK_50);
            PS2_CLK <= 1'b1;
        end
        repeat (10) @(posedge CLOCK_50);
        PS2_DAT <= 1'b1;
        repeat (10) @(posedge CLOCK_50);
        if (bit_limit == 11) begin
            model_frame(frame_code, !bad_parity);
        end
    endtask

    task automatic read_bus(input string name, input bus_addr_t addr, input bit enable);
        @(posedge CLOCK_50);
        bus_address     <= addr;
        bus_read_enable <= enable;
        @(negedge CLOCK_50);
        exp_q.push_back(model_read(addr, enable));
        act_q.push_back(bus_read_data);
        name_q.push_back(name);
        @(posedge CLOCK_50);
        bus_read_enable <= 1'b0;
    endtask

    task automatic wait_vector(input string name, input irq_vec_t value);
        int cycles;
        cycles = 0;
        @(negedge CLOCK_50);
        while (interrupt_vector !== value && cycles < 2000) begin
            @(negedge CLOCK_50);
            cycles++;
        end
        if (interrupt_vector !== value) begin
            fail_run($sformatf("Timed out in %s waiting for interrupt_vector to become %0d",
                               name, value));
        end
    endtask

    task automatic ack_interrupt(input string name);
        @(posedge CLOCK_50);
        interrupt_done <= 1'b1;
        @(posedge CLOCK_50);
        interrupt_done <= 1'b0;
        wait_vector(name, '0);
    endtask

    always @(posedge CLOCK_50) begin : compare_reads
        string     check_name;
        bus_data_t expected;
        bus_data_t actual;
        while (exp_q.size() > 0) begin
            check_name = name_q.pop_front();
            expected   = exp_q.pop_front();
            actual     = act_q.pop_front();
            assert (actual === expected) else begin
                fail_run($sformatf("FAIL %s: expected %h, actual %h",
                                   check_name, expected, actual));
            end
        end
    end

    initial begin
        CLOCK_50        = 1'b0;
        KEY0            = 1'b0;
        PS2_CLK         = 1'b1;
        PS2_DAT         = 1'b1;
        bus_address     = '0;
        bus_read_enable = 1'b0;
        interrupt_done  = 1'b0;
        model_armed     = 1'b0;
        model_overflow  = 1'b0;
        model_frame_err = 1'b0;
        void'($urandom(10929));
        repeat (8) @(posedge CLOCK_50);
        KEY0 <= 1'b1;
        repeat (4) @(posedge CLOCK_50);

        // Quiet state after reset
        @(negedge CLOCK_50);
        check_value("reset vector", 64'd0, 64'(interrupt_vector));
        check_value("reset LEDG", 64'd0, 64'(LEDG));
        read_bus("reset status", STATUS_ADDR, 1'b1);
        read_bus("unmapped read", KEY_BASE + 64'h100, 1'b1);
        // Unmapped address, so an ignored enable would show up as a nonzero word
        read_bus("enable low", KEY_BASE + 64'h100, 1'b0);

        // Single make codes
        for (int k = 0; k < 6; k++) begin
            code = scan_code_t'($urandom_range(8'hEF, 8'h01));
            send_frame(code, 1'b0, 11);
            wait_vector("make code irq", KEY_IRQ);
            read_bus("make code data", KEY_BASE, 1'b1);
            @(negedge CLOCK_50);
            check_value("make code LEDG", 64'(code), 64'(LEDG));
            ack_interrupt("make code done");
        end

        // Break prefix then code gives one released event
        send_frame(8'hF0, 1'b0, 11);
        send_frame(8'h1C, 1'b0, 11);
        wait_vector("break irq", KEY_IRQ);
        read_bus("break data", KEY_BASE, 1'b1);
        read_bus("break only one event", STATUS_ADDR, 1'b1);
        @(negedge CLOCK_50);
        check_value("break LEDG", 64'h1C, 64'(LEDG));
        ack_interrupt("break done");

        // Overrun the FIFO by three
        for (int k = 0; k < FIFO_DEPTH + 3; k++) begin
            send_frame(scan_code_t'(8'h20 + k), 1'b0, 11);
        end
        wait_vector("overflow irq", KEY_IRQ);
        read_bus("status with overflow", STATUS_ADDR, 1'b1);
        read_bus("status after clear", STATUS_ADDR, 1'b1);
        for (int k = 0; k < FIFO_DEPTH; k++) begin
            read_bus("fifo order", KEY_BASE, 1'b1);
        end
        read_bus("empty data read", KEY_BASE, 1'b1);
        ack_interrupt("overflow done");

        // Bad parity frame
        send_frame(8'h2B, 1'b1, 11);
        @(negedge CLOCK_50);
        check_value("bad parity no irq", 64'd0, 64'(interrupt_vector));
        read_bus("frame error status", STATUS_ADDR, 1'b1);
        read_bus("frame error cleared", STATUS_ADDR, 1'b1);

        // Cut-off frame, then silence past the frame timeout
        send_frame(8'h33, 1'b0, 4);
        repeat (400) @(posedge CLOCK_50);
        send_frame(8'h2A, 1'b0, 11);
        wait_vector("after truncation irq", KEY_IRQ);
        read_bus("after truncation data", KEY_BASE, 1'b1);
        read_bus("after truncation status", STATUS_ADDR, 1'b1);
        ack_interrupt("after truncation done");

        repeat (3) @(posedge CLOCK_50);
        if (exp_q.size() == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("Some bus reads were never compared");
        end
    end

endmodule

// File: kbd_periph.f
src/kbd_pkg.sv
src/ps2_receiver.sv
src/key_fifo.sv
src/kbd_bus_port.sv
src/kbd_top.sv
verification/kbd_tb.sv
